// File: compile.f
logic/soc_pkg.sv
logic/mem_bus_if.sv
logic/rst_gen.sv
logic/debug_gate.sv
logic/bus_demux.sv
logic/boot_rom.sv
logic/sram_mem.sv
logic/soc_top.sv
verification/soc_top_sva.sv
verification/tb_soc_top.sv

// File: Makefile
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the SoC testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -f compile.f \
	  --top-module tb_soc_top -Mdir $(OBJ_DIR) -o tb_soc_top
	./$(OBJ_DIR)/tb_soc_top | tee /dev/stderr | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/tb_soc_top.sv
// Testbench for soc_top that drives ROM, SRAM, error decode, debug and ndmreset stimulus
`timescale 1ns/100ps

module tb_soc_top;
  import soc_pkg::*;

  localparam int unsigned HoldoffCycles = 20;
  localparam int unsigned RamWords      = 256;
  localparam int unsigned Timeout       = 100;
  localparam int unsigned RomIdxW       = $clog2(ROM_WORDS);
  localparam int unsigned RamIdxW       = $clog2(RamWords);

  logic              clk_i;
  logic              rst_ni;
  logic              ndmreset_i;
  logic              req_i;
  logic              we_i;
  logic [ADDR_W-1:0] addr_i;
  logic [BE_W-1:0]   be_i;
  logic [DATA_W-1:0] wdata_i;
  logic              rvalid_o;
  logic [DATA_W-1:0] rdata_o;
  logic              err_o;
  logic              dbg_req_i;
  logic              debug_en_i;
  logic              debug_req_o;
  logic              sys_rst_no;

  // Shadow RAM and responses still owed by the DUT
  logic [DATA_W-1:0] shadow [RamWords];
  logic [DATA_W-1:0] exp_data_q [$];
  logic              exp_err_q [$];
  logic [DATA_W-1:0] exp_data;
  logic              exp_err;
  int unsigned       chk_errs;
  int unsigned       tmo_errs;

  soc_top #(
    .HoldoffCycles ( HoldoffCycles ),
    .RamWords      ( RamWords      )
  ) DUT (.*);

  bind soc_top soc_top_sva #(
    .HoldoffCycles ( HoldoffCycles ),
    .RamWords      ( RamWords      )
  ) i_soc_top_sva (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_i  ),
    .sys_rst_ni  ( sys_rst_n   ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .rvalid_i    ( rvalid_o    ),
    .rdata_i     ( rdata_o     ),
    .err_i       ( err_o       ),
    .dbg_req_i   ( dbg_req_i   ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_i ( debug_req_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [ADDR_W-1:0] ram_addr(input int unsigned idx);
    return DRAM_BASE + ADDR_W'(idx * BE_W);
  endfunction

  // --------------------
  // Request driver
  // --------------------
  task automatic access(input logic we, input logic [ADDR_W-1:0] addr,
                        input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0]  exp_rd;
    logic               exp_er;
    logic [RomIdxW-1:0] rom_idx;
    logic [RamIdxW-1:0] ram_idx;
    exp_rd  = '0;
    exp_er  = 1'b1;
    rom_idx = RomIdxW'((addr - ROM_BASE) >> BYTE_OFS_W);
    ram_idx = RamIdxW'((addr - DRAM_BASE) >> BYTE_OFS_W);
    if (!we && addr >= ROM_BASE && addr < ROM_BASE + ROM_WORDS * BE_W) begin
      exp_rd = ROM_IMAGE[rom_idx];
      exp_er = 1'b0;
    end else if (addr >= DRAM_BASE && addr < DRAM_BASE + RamWords * BE_W) begin
      exp_er = 1'b0;
      if (we) begin
        // Only enabled bytes change
        for (int b = 0; b < BE_W; b++) begin
          if (be[b]) begin
            shadow[ram_idx][b*8 +: 8] = wdata[b*8 +: 8];
          end
        end
      end else begin
        exp_rd = shadow[ram_idx];
      end
    end
    @(posedge clk_i);
    #1;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    exp_data_q.push_back(exp_rd);
    exp_err_q.push_back(exp_er);
  endtask

  // Ends a burst and waits until every response has arrived
  task automatic finish_burst();
    int unsigned n;
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    we_i  = 1'b0;
    n     = 0;
    while (exp_data_q.size() != 0 && n < Timeout) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_data_q.size() != 0) begin
      $display("Timeout at %0t: %0d responses never arrived", $time, exp_data_q.size());
      tmo_errs++;
      exp_data_q.delete();
      exp_err_q.delete();
    end
  endtask

  task automatic wait_sys_rst(output int unsigned edges);
    edges = 0;
    while (!sys_rst_no && edges < Timeout) begin
      @(posedge clk_i);
      #1;
      edges++;
    end
    if (!sys_rst_no) begin
      $display("Timeout at %0t: system reset was never released", $time);
      tmo_errs++;
    end
  endtask

  // Response checker sampled mid-cycle
  always @(negedge clk_i) begin
    if (rvalid_o) begin
      if (exp_data_q.size() == 0) begin
        $display("ERR %0t: response arrived with no request outstanding", $time);
        chk_errs++;
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_err  = exp_err_q.pop_front();
        assert (rdata_o == exp_data && err_o == exp_err) else begin
          $display("ERR %0t: rdata %h err %b, expected rdata %h err %b",
                   $time, rdata_o, err_o, exp_data, exp_err);
          chk_errs++;
        end
      end
    end
  end

  initial begin
    int unsigned edges;
    chk_errs   = 0;
    tmo_errs   = 0;
    void'($urandom(61));
    rst_ni     = 1'b1;
    ndmreset_i = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    be_i       = '0;
    wdata_i    = '0;
    // Debug requested from the start so the holdoff is visible
    dbg_req_i  = 1'b1;
    debug_en_i = 1'b1;
    #1 rst_ni  = 1'b0;
    repeat (2) @(posedge clk_i);
    #1 rst_ni  = 1'b1;
    wait_sys_rst(edges);

    // --------------------
    // Boot ROM
    // --------------------
    for (int i = 0; i < ROM_WORDS; i++) begin
      access(1'b0, ROM_BASE + ADDR_W'(i * BE_W), '1, '0);
      finish_burst();
    end
    for (int i = ROM_WORDS - 1; i >= 0; i--) begin
      access(1'b0, ROM_BASE + ADDR_W'(i * BE_W), '1, '0);
    end
    access(1'b1, ROM_BASE + 32'h8, '1, 64'h1);
    finish_burst();

    // --------------------
    // SRAM with byte enables
    // --------------------
    for (int i = 0; i < RamWords; i++) begin
      access(1'b1, ram_addr(i), '1, {ram_addr(i), ~ram_addr(i)});
    end
    finish_burst();
    repeat (40) begin
      access(1'b1, ram_addr($urandom_range(RamWords - 1)), BE_W'($urandom),
             {$urandom, $urandom});
    end
    finish_burst();
    for (int i = 0; i < RamWords; i++) begin
      access(1'b0, ram_addr(i), '1, '0);
    end
    finish_burst();

    // GPIO window and unmapped holes
    access(1'b0, GPIO_BASE + ($urandom % GPIO_LEN), '1, '0);
    access(1'b1, GPIO_BASE + ($urandom % GPIO_LEN), '1, 64'h55);
    access(1'b0, 32'h0000_0000, '1, '0);
    access(1'b0, 32'h2000_0000, '1, '0);
    access(1'b0, ROM_BASE + ADDR_W'(ROM_WORDS * BE_W), '1, '0);
    access(1'b1, ram_addr(RamWords), '1, 64'h77);
    access(1'b0, 32'hffff_fff8, '1, '0);
    finish_burst();

    // Debug request once the holdoff is over
    repeat (20) begin
      @(posedge clk_i);
      #1;
      dbg_req_i  = 1'($urandom);
      debug_en_i = 1'($urandom);
    end

    // --------------------
    // ndmreset pulse
    // --------------------
    // Write issued while in reset must not land in the SRAM
    @(posedge clk_i);
    #1;
    ndmreset_i = 1'b1;
    req_i      = 1'b1;
    we_i       = 1'b1;
    addr_i     = ram_addr(3);
    be_i       = '1;
    wdata_i    = ~shadow[3];
    @(posedge clk_i);
    #1;
    assert (!sys_rst_no) else begin
      $display("ERR %0t: sys_rst_no high during ndmreset", $time);
      chk_errs++;
    end
    req_i      = 1'b0;
    we_i       = 1'b0;
    ndmreset_i = 1'b0;
    wait_sys_rst(edges);
    assert (edges == 2) else begin
      $display("ERR %0t: reset released after %0d edges, expected 2", $time, edges);
      chk_errs++;
    end
    for (int i = 0; i < 16; i++) begin
      access(1'b0, ram_addr(i), '1, '0);
    end
    finish_burst();

    repeat (4) @(posedge clk_i);
    $display("Error counts: data %0d, timeout %0d, assertion %0d",
             chk_errs, tmo_errs, DUT.i_soc_top_sva.sva_errs);
    if (chk_errs + tmo_errs + DUT.i_soc_top_sva.sva_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: verification/soc_top_sva.sv
// Concurrent checks on bus timing, decode, reset release and debug holdoff, bound into soc_top
`timescale 1ns/100ps

module soc_top_sva #(
  parameter int unsigned HoldoffCycles = 500,
  parameter int unsigned RamWords      = 256
) (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       ndmreset_i,
  input logic                       sys_rst_ni,
  input logic                       req_i,
  input logic                       we_i,
  input logic [soc_pkg::ADDR_W-1:0] addr_i,
  input logic                       rvalid_i,
  input logic [soc_pkg::DATA_W-1:0] rdata_i,
  input logic                       err_i,
  input logic                       dbg_req_i,
  input logic                       debug_en_i,
  input logic                       debug_req_i
);
  import soc_pkg::*;

  int unsigned sva_errs = 0;
  int unsigned cyc_q;
  logic        mapped;

  // ROM reads and anything inside the SRAM window
  assign mapped = (!we_i && addr_i >= ROM_BASE && addr_i < ROM_BASE + ROM_WORDS * BE_W)
               || (addr_i >= DRAM_BASE && addr_i < DRAM_BASE + RamWords * BE_W);

  // Cycles since power-on reset, saturating at the holdoff
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_q <= 0;
    end else if (cyc_q < HoldoffCycles) begin
      cyc_q <= cyc_q + 1;
    end
  end

  // --------------------
  // Bus handshake
  // --------------------
  resp_after_req: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    req_i |=> rvalid_i)
    else begin
      $error("No response in the cycle after a request");
      sva_errs++;
    end

  no_resp_without_req: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    !req_i |=> !rvalid_i)
    else begin
      $error("Response without a request");
      sva_errs++;
    end

  quiet_in_reset: assert property (@(posedge clk_i) !sys_rst_ni |-> !rvalid_i && !err_i)
    else begin
      $error("Bus active while system reset is low");
      sva_errs++;
    end

  // --------------------
  // Decode
  // --------------------
  err_for_unmapped: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    req_i && !mapped |=> err_i && rdata_i == '0)
    else begin
      $error("Unmapped access did not return err with zero data");
      sva_errs++;
    end

  no_err_for_mapped: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    req_i && mapped |=> !err_i)
    else begin
      $error("Mapped access returned err");
      sva_errs++;
    end

  rst_release: assert property (@(posedge clk_i)
    $rose(sys_rst_ni) |-> $past(rst_ni && !ndmreset_i) && $past(rst_ni && !ndmreset_i, 2))
    else begin
      $error("System reset released before two quiet edges");
      sva_errs++;
    end

  // --------------------
  // Debug holdoff
  // --------------------
  debug_held: assert property (@(posedge clk_i) cyc_q < HoldoffCycles |-> !debug_req_i)
    else begin
      $error("Debug request raised inside the holdoff window");
      sva_errs++;
    end

  debug_follows: assert property (@(posedge clk_i)
    cyc_q >= HoldoffCycles |-> debug_req_i == (dbg_req_i && debug_en_i))
    else begin
      $error("Debug request does not follow request and enable");
      sva_errs++;
    end

endmodule

// File: logic/soc_top.sv
// SoC top level with reset, debug gating, bus demux and memories on plain ports
`timescale 1ns/100ps

module soc_top #(
  parameter int unsigned HoldoffCycles = 500,
  parameter int unsigned RamWords      = 256
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       ndmreset_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [soc_pkg::ADDR_W-1:0] addr_i,
  input  logic [soc_pkg::BE_W-1:0]   be_i,
  input  logic [soc_pkg::DATA_W-1:0] wdata_i,
  output logic                       rvalid_o,
  output logic [soc_pkg::DATA_W-1:0] rdata_o,
  output logic                       err_o,
  input  logic                       dbg_req_i,
  input  logic                       debug_en_i,
  output logic                       debug_req_o,
  output logic                       sys_rst_no
);

  // Bus side reset, power-on combined with ndmreset
  logic sys_rst_n;

  mem_bus_if rom_bus ();
  mem_bus_if ram_bus ();

  rst_gen i_rst_gen (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .rst_no     ( sys_rst_n  )
  );

  assign sys_rst_no = sys_rst_n;

  // Debug holdoff runs on power-on reset only
  debug_gate #(
    .HoldoffCycles ( HoldoffCycles )
  ) i_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .dbg_req_i   ( dbg_req_i   ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

  // --------------------
  // Memory-mapped bus
  // --------------------
  bus_demux #(
    .RamWords ( RamWords )
  ) i_bus_demux (
    .clk_i    ( clk_i     ),
    .rst_ni   ( sys_rst_n ),
    .req_i    ( req_i     ),
    .we_i     ( we_i      ),
    .addr_i   ( addr_i    ),
    .be_i     ( be_i      ),
    .wdata_i  ( wdata_i   ),
    .rvalid_o ( rvalid_o  ),
    .rdata_o  ( rdata_o   ),
    .err_o    ( err_o     ),
    .rom_o    ( rom_bus   ),
    .ram_o    ( ram_bus   )
  );

  boot_rom i_boot_rom (
    .clk_i  ( clk_i     ),
    .rst_ni ( sys_rst_n ),
    .bus_i  ( rom_bus   )
  );

  sram_mem #(
    .RamWords ( RamWords )
  ) i_sram_mem (
    .clk_i  ( clk_i     ),
    .rst_ni ( sys_rst_n ),
    .bus_i  ( ram_bus   )
  );

endmodule

// File: logic/sram_mem.sv
// Byte-enabled word SRAM target standing in for DRAM with one-cycle read latency
`timescale 1ns/100ps

module sram_mem #(
  parameter int unsigned RamWords = 256
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  mem_bus_if.slave bus_i
);
  import soc_pkg::*;

  localparam int unsigned IdxW = $clog2(RamWords);

  logic [DATA_W-1:0] mem_q [RamWords];
  logic [IdxW-1:0]   word_idx;
  logic              wr_en;

  assign word_idx = bus_i.addr[BYTE_OFS_W +: IdxW];

  // No writes land while the bus is held in reset
  assign wr_en = bus_i.req & bus_i.we & rst_ni;

  // --------------------
  // Storage
  // --------------------
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int unsigned b = 0; b < BE_W; b++) begin
        if (bus_i.be[b]) begin
          mem_q[word_idx][b*8 +: 8] <= bus_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      bus_i.rdata <= bus_i.we ? '0 : mem_q[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
    end
  end

  assign bus_i.err = 1'b0;

endmodule

// File: logic/boot_rom.sv
// Boot ROM target returning the package image one cycle after each read strobe
`timescale 1ns/100ps

module boot_rom (
  input  logic     clk_i,
  input  logic     rst_ni,
  mem_bus_if.slave bus_i
);
  import soc_pkg::*;

  localparam int unsigned IdxW = $clog2(ROM_WORDS);

  logic [IdxW-1:0] word_idx;

  // Wraps modulo ROM_WORDS inside the window
  assign word_idx = bus_i.addr[BYTE_OFS_W +: IdxW];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
    end
  end

  // Read data register
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      bus_i.rdata <= ROM_IMAGE[word_idx];
    end
  end

  // Writes never reach the ROM
  assign bus_i.err = 1'b0;

endmodule

// File: logic/bus_demux.sv
// Single-master address decoder routing requests to ROM, SRAM or the error responder
`timescale 1ns/100ps

module bus_demux #(
  parameter int unsigned RamWords = 256
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [soc_pkg::ADDR_W-1:0] addr_i,
  input  logic [soc_pkg::BE_W-1:0]   be_i,
  input  logic [soc_pkg::DATA_W-1:0] wdata_i,
  output logic                       rvalid_o,
  output logic [soc_pkg::DATA_W-1:0] rdata_o,
  output logic                       err_o,
  mem_bus_if.master                  rom_o,
  mem_bus_if.master                  ram_o
);
  import soc_pkg::*;

  localparam logic [ADDR_W-1:0] RomEnd = ROM_BASE + ADDR_W'(ROM_WORDS * BE_W);
  localparam logic [ADDR_W-1:0] RamEnd = DRAM_BASE + ADDR_W'(RamWords * BE_W);

  target_e tgt;
  target_e tgt_q;
  logic    err_vld_q;
  logic    rom_hit;
  logic    ram_hit;

  // --------------------
  // Address decode
  // --------------------
  assign rom_hit  = (addr_i >= ROM_BASE) && (addr_i < RomEnd);
  assign ram_hit  = (addr_i >= DRAM_BASE) && (addr_i < RamEnd);

  // GPIO window and unmapped addresses fall through to the error responder
  always_comb begin
    tgt = TGT_ERR;
    if (rom_hit && !we_i) begin
      tgt = TGT_ROM;
    end else if (ram_hit) begin
      tgt = TGT_RAM;
    end
  end

  // Strobe goes to exactly one target and the payload is shared
  assign rom_o.req   = req_i && (tgt == TGT_ROM);
  assign rom_o.we    = we_i;
  assign rom_o.addr  = addr_i;
  assign rom_o.be    = be_i;
  assign rom_o.wdata = wdata_i;

  assign ram_o.req   = req_i && (tgt == TGT_RAM);
  assign ram_o.we    = we_i;
  assign ram_o.addr  = addr_i;
  assign ram_o.be    = be_i;
  assign ram_o.wdata = wdata_i;

  // --------------------
  // Response select
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tgt_q     <= TGT_ERR;
      err_vld_q <= 1'b0;
    end else begin
      err_vld_q <= req_i && (tgt == TGT_ERR);
      if (req_i) begin
        tgt_q <= tgt;
      end
    end
  end

  always_comb begin
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    case (tgt_q)
      TGT_ROM: begin
        rvalid_o = rom_o.rvalid;
        rdata_o  = rom_o.rdata;
        err_o    = rom_o.err;
      end
      TGT_RAM: begin
        rvalid_o = ram_o.rvalid;
        rdata_o  = ram_o.rdata;
        err_o    = ram_o.err;
      end
      default: begin
        // Error responder answers with zero data
        rvalid_o = err_vld_q;
        err_o    = err_vld_q;
      end
    endcase
  end

endmodule

// File: logic/debug_gate.sv
// Holds the core debug request low after power-on and gates it with debug enable
`timescale 1ns/100ps

module debug_gate #(
  parameter int unsigned HoldoffCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dbg_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  localparam int unsigned CntW = (HoldoffCycles > 0) ? $clog2(HoldoffCycles + 1) : 1;

  logic [CntW-1:0] holdoff_q;
  logic            holdoff_done;

  assign holdoff_done = (holdoff_q == '0);

  // Gives boot code time before the first debug request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      holdoff_q <= CntW'(HoldoffCycles);
    end else if (!holdoff_done) begin
      holdoff_q <= holdoff_q - 1'b1;
    end
  end

  // Pass-through once the window has elapsed
  assign debug_req_o = holdoff_done & debug_en_i & dbg_req_i;

endmodule

// File: logic/rst_gen.sv
// Bus reset generator with asynchronous assertion and two-stage synchronous release
`timescale 1ns/100ps

module rst_gen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic rst_no
);

  logic rst_src_n;
  logic sync_q1;
  logic sync_q2;

  // Either source pulls the bus side into reset at once
  assign rst_src_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_src_n) begin
    if (!rst_src_n) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= 1'b1;
      sync_q2 <= sync_q1;
    end
  end

  assign rst_no = sync_q2;

endmodule

// File: logic/mem_bus_if.sv
// Strobe request and response bus between the demux and each memory target
`timescale 1ns/100ps

interface mem_bus_if;
  import soc_pkg::*;

  // Request side, one-cycle strobe
  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [BE_W-1:0]   be;
  logic [DATA_W-1:0] wdata;

  // Response side, one cycle after req
  logic              rvalid;
  logic [DATA_W-1:0] rdata;
  logic              err;

  modport master (
    output req, we, addr, be, wdata,
    input  rvalid, rdata, err
  );

  modport slave (
    input  req, we, addr, be, wdata,
    output rvalid, rdata, err
  );

endinterface

// File: logic/soc_pkg.sv
// Bus widths, address map and boot ROM image shared by all SoC RTL files
package soc_pkg;

  // --------------------
  // Bus geometry
  // --------------------
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 64;
  localparam int unsigned BE_W       = DATA_W / 8;
  localparam int unsigned BYTE_OFS_W = 3;

  // --------------------
  // Address map
  // --------------------
  localparam logic [ADDR_W-1:0] ROM_BASE  = 32'h0000_1000;
  localparam int unsigned       ROM_WORDS = 8;
  localparam logic [ADDR_W-1:0] GPIO_BASE = 32'h4000_0000;
  localparam logic [ADDR_W-1:0] GPIO_LEN  = 32'h0000_1000;
  localparam logic [ADDR_W-1:0] DRAM_BASE = 32'h8000_0000;

  // Boot words, index 0 sits at ROM_BASE
  localparam logic [DATA_W-1:0] ROM_IMAGE [ROM_WORDS] = '{
    64'h0182_b283_0000_0297,
    64'h0000_0013_f140_2573,
    64'h0202_8067_0000_0597,
    64'h1050_0073_0000_0013,
    64'hdead_beef_0000_0000,
    64'h0000_0000_8000_0000,
    64'h0123_4567_89ab_cdef,
    64'hfedc_ba98_7654_3210
  };

  // Response source chosen by the address decoder
  typedef enum logic [1:0] {
    TGT_ROM = 2'd0,
    TGT_RAM = 2'd1,
    TGT_ERR = 2'd2
  } target_e;

endpackage
